/* verilog/rmii_macros.svh */
`ifndef RMII_MACROS_SVH
`define RMII_MACROS_SVH

// RMII symbol and byte widths
`define RMII_DIBIT_WIDTH        2
`define BYTE_WIDTH              8

// Ethernet CRC-32 in reflected form, register preset to all ones
`define CRC_WIDTH               32
`define CRC_POLY_REFLECTED      32'hEDB8_8320
`define CRC_RESIDUE             32'hDEBB_20E3

// Framing
`define SFD_BYTE                8'hD5
`define FCS_BYTES               4

// Frame buffer
`define RX_BUFFER_DEPTH         2048
`define RX_BUFFER_ADDR_WIDTH    11
`define DROP_COUNT_WIDTH        16

`endif

/* verilog/rmii_pkg.sv */
`default_nettype none
`include "rmii_macros.svh"

package rmii_pkg;

    typedef logic [`RMII_DIBIT_WIDTH-1:0]     dibit_t;
    typedef logic [`BYTE_WIDTH-1:0]           byte_t;
    typedef logic [`CRC_WIDTH-1:0]            crc_t;
    // Last marker in the top bit
    typedef logic [`BYTE_WIDTH:0]             rx_word_t;
    typedef logic [`RX_BUFFER_ADDR_WIDTH-1:0] buffer_addr_t;
    typedef logic [`DROP_COUNT_WIDTH-1:0]     drop_count_t;

    typedef enum logic [1:0] {
        packager_idle,
        packager_preamble,
        packager_data
    } packager_state_t;

    typedef enum logic [1:0] {
        checker_filling,
        checker_streaming,
        checker_discard
    } checker_state_t;

endpackage

`default_nettype wire

/* verilog/byte_stream_if.sv */
`default_nettype none

// No ready, the line cannot be stalled
interface byte_stream_if;

    rmii_pkg::byte_t data;
    logic            valid;
    logic            last;
    logic            error;

    modport source (
        output data,
        output valid,
        output last,
        output error
    );

    modport sink (
        input  data,
        input  valid,
        input  last,
        input  error
    );

endinterface

`default_nettype wire

/* verilog/rmii_byte_packager.sv */
`default_nettype none
`include "rmii_macros.svh"

module rmii_byte_packager (
    input  wire                   clock,
    input  wire                   reset,
    input  wire rmii_pkg::dibit_t rmii_receive_data,
    input  wire                   rmii_receive_data_enable,
    input  wire                   rmii_receive_data_error,
    byte_stream_if.source         bytes_out
);

    rmii_pkg::packager_state_t state;
    rmii_pkg::byte_t           shift;
    rmii_pkg::byte_t           next_shift;
    rmii_pkg::byte_t           held_byte;
    logic                      held_valid;
    logic [1:0]                dibit_count;
    logic                      error_seen;
    logic                      byte_done;
    logic                      frame_end;

    // Dibits arrive LSB first, so they enter at the top
    assign next_shift = {rmii_receive_data, shift[`BYTE_WIDTH-1:`RMII_DIBIT_WIDTH]};

    assign byte_done  = (state == rmii_pkg::packager_data) && rmii_receive_data_enable
                        && (dibit_count == 2'd3);
    assign frame_end  = (state == rmii_pkg::packager_data) && !rmii_receive_data_enable;

    //////////////////////////////////////////////////////////////////////
    // Frame FSM

    always_ff @(posedge clock) begin
        if (reset) begin
            state           <= rmii_pkg::packager_idle;
            held_valid      <= 1'b0;
            dibit_count     <= '0;
            error_seen      <= 1'b0;
            bytes_out.valid <= 1'b0;
            bytes_out.last  <= 1'b0;
            bytes_out.error <= 1'b0;
        end else begin
            bytes_out.valid <= 1'b0;
            case (state)
                rmii_pkg::packager_idle: begin
                    if (rmii_receive_data_enable) begin
                        error_seen <= rmii_receive_data_error;
                        state      <= rmii_pkg::packager_preamble;
                    end
                end
                rmii_pkg::packager_preamble: begin
                    if (!rmii_receive_data_enable) begin
                        state <= rmii_pkg::packager_idle;
                    end else begin
                        error_seen <= error_seen | rmii_receive_data_error;
                        if (next_shift == `SFD_BYTE) begin
                            state       <= rmii_pkg::packager_data;
                            dibit_count <= '0;
                            held_valid  <= 1'b0;
                        end
                    end
                end
                rmii_pkg::packager_data: begin
                    if (rmii_receive_data_enable) begin
                        error_seen  <= error_seen | rmii_receive_data_error;
                        dibit_count <= dibit_count + 2'd1;
                        // Release the previous byte, it is not the last one
                        if (byte_done) begin
                            held_valid      <= 1'b1;
                            bytes_out.valid <= held_valid;
                            bytes_out.last  <= 1'b0;
                            bytes_out.error <= 1'b0;
                        end
                    end else begin
                        state           <= rmii_pkg::packager_idle;
                        held_valid      <= 1'b0;
                        bytes_out.valid <= held_valid;
                        bytes_out.last  <= 1'b1;
                        // partial byte at the end counts as an error
                        bytes_out.error <= error_seen | (dibit_count != 2'd0);
                    end
                end
                default: begin
                    state <= rmii_pkg::packager_idle;
                end
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Byte assembly

    always_ff @(posedge clock) begin
        if (rmii_receive_data_enable) begin
            shift <= next_shift;
        end
        if (byte_done) begin
            held_byte <= next_shift;
        end
        if (byte_done || frame_end) begin
            bytes_out.data <= held_byte;
        end
    end

endmodule

`default_nettype wire

/* verilog/frame_checker.sv */
`default_nettype none
`include "rmii_macros.svh"

module frame_checker (
    input  wire           clock,
    input  wire           reset,
    byte_stream_if.sink   bytes_in,
    byte_stream_if.source payload_out
);

    rmii_pkg::checker_state_t          state;
    rmii_pkg::byte_t                   delay_line [`FCS_BYTES];
    logic [$clog2(`FCS_BYTES)-1:0]     fill_count;
    rmii_pkg::crc_t                    crc;
    rmii_pkg::crc_t                    crc_next;
    logic                              frame_bad;
    logic                              shift_enable;

    function automatic rmii_pkg::crc_t crc_update(
        input rmii_pkg::crc_t  crc_in,
        input rmii_pkg::byte_t data
    );
        rmii_pkg::crc_t c;
        c = crc_in ^ {{(`CRC_WIDTH-`BYTE_WIDTH){1'b0}}, data};
        for (int i = 0; i < `BYTE_WIDTH; i++) begin
            if (c[0]) begin
                c = (c >> 1) ^ `CRC_POLY_REFLECTED;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    assign crc_next     = crc_update(crc, bytes_in.data);
    // FCS included, so a good frame leaves the fixed residue
    assign frame_bad    = (crc_next != `CRC_RESIDUE) || bytes_in.error;
    assign shift_enable = bytes_in.valid && (state != rmii_pkg::checker_discard);

    //////////////////////////////////////////////////////////////////////
    // Verdict FSM

    always_ff @(posedge clock) begin
        if (reset) begin
            state             <= rmii_pkg::checker_filling;
            fill_count        <= '0;
            crc               <= '1;
            payload_out.valid <= 1'b0;
            payload_out.last  <= 1'b0;
            payload_out.error <= 1'b0;
        end else begin
            payload_out.valid <= 1'b0;
            case (state)
                rmii_pkg::checker_filling: begin
                    if (bytes_in.valid) begin
                        if (bytes_in.last) begin
                            // Four bytes or fewer, nothing to emit
                            state      <= rmii_pkg::checker_discard;
                            fill_count <= '0;
                            crc        <= '1;
                        end else begin
                            crc        <= crc_next;
                            fill_count <= fill_count + 1'b1;
                            if (fill_count == ($clog2(`FCS_BYTES))'(`FCS_BYTES - 1)) begin
                                state <= rmii_pkg::checker_streaming;
                            end
                        end
                    end
                end
                rmii_pkg::checker_streaming: begin
                    if (bytes_in.valid) begin
                        payload_out.valid <= 1'b1;
                        payload_out.last  <= bytes_in.last;
                        payload_out.error <= bytes_in.last && frame_bad;
                        if (bytes_in.last) begin
                            state      <= rmii_pkg::checker_filling;
                            fill_count <= '0;
                            crc        <= '1;
                        end else begin
                            crc <= crc_next;
                        end
                    end
                end
                rmii_pkg::checker_discard: begin
                    // Bad last with no payload so the buffer counts it
                    payload_out.valid <= 1'b1;
                    payload_out.last  <= 1'b1;
                    payload_out.error <= 1'b1;
                    state             <= rmii_pkg::checker_filling;
                end
                default: begin
                    state <= rmii_pkg::checker_filling;
                end
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // FCS delay line

    always_ff @(posedge clock) begin
        if (shift_enable) begin
            delay_line[0] <= bytes_in.data;
            for (int i = 1; i < `FCS_BYTES; i++) begin
                delay_line[i] <= delay_line[i-1];
            end
        end
        if (bytes_in.valid && (state == rmii_pkg::checker_streaming)) begin
            payload_out.data <= delay_line[`FCS_BYTES-1];
        end
    end

endmodule

`default_nettype wire

/* verilog/receive_buffer.sv */
`default_nettype none
`include "rmii_macros.svh"

module receive_buffer (
    input  wire                   clock,
    input  wire                   reset,
    byte_stream_if.sink           payload_in,
    input  wire                   receive_data_enable,
    output rmii_pkg::rx_word_t    receive_data,
    output logic                  receive_data_valid,
    output rmii_pkg::drop_count_t dropped_frames
);

    rmii_pkg::rx_word_t     memory [`RX_BUFFER_DEPTH];
    // Wrap bits tell full from empty
    rmii_pkg::buffer_addr_t write_addr;
    rmii_pkg::buffer_addr_t commit_addr;
    rmii_pkg::buffer_addr_t read_addr;
    logic                   write_wrap;
    logic                   commit_wrap;
    logic                   read_wrap;
    logic                   overflow;
    logic                   full;
    logic                   committed_available;
    logic                   write_enable;
    logic                   pop;
    logic                   load_output;

    assign full                = (write_addr == read_addr) && (write_wrap != read_wrap);
    assign committed_available = (read_addr != commit_addr) || (read_wrap != commit_wrap);
    assign write_enable        = payload_in.valid && !full && !overflow
                                 && !(payload_in.last && payload_in.error);
    assign pop                 = receive_data_valid && receive_data_enable;
    assign load_output         = committed_available && (!receive_data_valid || pop);

    //////////////////////////////////////////////////////////////////////
    // Pointers, commit and rollback

    always_ff @(posedge clock) begin
        if (reset) begin
            write_addr         <= '0;
            write_wrap         <= 1'b0;
            commit_addr        <= '0;
            commit_wrap        <= 1'b0;
            read_addr          <= '0;
            read_wrap          <= 1'b0;
            overflow           <= 1'b0;
            dropped_frames     <= '0;
            receive_data_valid <= 1'b0;
        end else begin
            if (write_enable) begin
                {write_wrap, write_addr} <= {write_wrap, write_addr} + 1'b1;
            end
            if (payload_in.valid && !payload_in.last && full) begin
                overflow <= 1'b1;
            end
            if (payload_in.valid && payload_in.last) begin
                overflow <= 1'b0;
                if (write_enable) begin
                    {commit_wrap, commit_addr} <= {write_wrap, write_addr} + 1'b1;
                end else begin
                    {write_wrap, write_addr} <= {commit_wrap, commit_addr};
                    dropped_frames           <= dropped_frames + 1'b1;
                end
            end
            // Read side, first word falls through
            if (load_output) begin
                {read_wrap, read_addr} <= {read_wrap, read_addr} + 1'b1;
                receive_data_valid     <= 1'b1;
            end else if (pop) begin
                receive_data_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (write_enable) begin
            memory[write_addr] <= {payload_in.last, payload_in.data};
        end
        if (load_output) begin
            receive_data <= memory[read_addr];
        end
    end

endmodule

`default_nettype wire

/* verilog/rmii_receiver.sv */
`default_nettype none

module rmii_receiver (
    input  wire                        clock,
    input  wire                        reset,
    input  wire rmii_pkg::dibit_t      rmii_receive_data,
    input  wire                        rmii_receive_data_enable,
    input  wire                        rmii_receive_data_error,
    input  wire                        receive_data_enable,
    output wire rmii_pkg::rx_word_t    receive_data,
    output wire                        receive_data_valid,
    output wire rmii_pkg::drop_count_t dropped_frames
);

    byte_stream_if packager_to_checker ();
    byte_stream_if checker_to_buffer ();

    //////////////////////////////////////////////////////////////////////
    // Dibits to bytes, then FCS check, then frame buffer

    rmii_byte_packager rmii_byte_packager (
        .clock                    (clock),
        .reset                    (reset),
        .rmii_receive_data        (rmii_receive_data),
        .rmii_receive_data_enable (rmii_receive_data_enable),
        .rmii_receive_data_error  (rmii_receive_data_error),
        .bytes_out                (packager_to_checker.source)
    );

    frame_checker frame_checker (
        .clock       (clock),
        .reset       (reset),
        .bytes_in    (packager_to_checker.sink),
        .payload_out (checker_to_buffer.source)
    );

    receive_buffer receive_buffer (
        .clock               (clock),
        .reset               (reset),
        .payload_in          (checker_to_buffer.sink),
        .receive_data_enable (receive_data_enable),
        .receive_data        (receive_data),
        .receive_data_valid  (receive_data_valid),
        .dropped_frames      (dropped_frames)
    );

endmodule

`default_nettype wire

/* test/clock_gen.sv */
`default_nettype none

module clock_gen (
    output logic clock,
    output logic reset
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    // Three clock edges with reset high
    initial begin
        reset = 1'b1;
        repeat (3) @(posedge clock);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

/* test/rmii_receiver_props.sv */
`default_nettype none

module rmii_receiver_props (
    input wire                        clock,
    input wire                        reset,
    input wire rmii_pkg::rx_word_t    receive_data,
    input wire                        receive_data_valid,
    input wire                        receive_data_enable,
    input wire rmii_pkg::drop_count_t dropped_frames,
    input wire                        payload_valid
);
    timeunit 1ns;
    timeprecision 1ps;

    int assertion_failures = 0;

    reset_clears_valid: assert property (@(posedge clock) reset |=> !receive_data_valid)
        else begin
            $error("receive_data_valid high after a reset cycle");
            assertion_failures++;
        end

    drops_never_decrease: assert property (@(posedge clock) disable iff (reset)
        dropped_frames >= $past(dropped_frames))
        else begin
            $error("dropped_frames went down");
            assertion_failures++;
        end

    // Held word must not change until the host takes it
    data_held_until_pop: assert property (@(posedge clock) disable iff (reset)
        (receive_data_valid && !receive_data_enable) |=> $stable(receive_data))
        else begin
            $error("receive_data changed while waiting for the host");
            assertion_failures++;
        end

    payload_valid_known: assert property (@(posedge clock) disable iff (reset)
        !$isunknown(payload_valid))
        else begin
            $error("payload valid is unknown");
            assertion_failures++;
        end

endmodule

`default_nettype wire

/* test/rmii_receiver_tb.sv */
`default_nettype none
`include "rmii_macros.svh"

module rmii_receiver_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int GAP_CLOCKS    = 12;
    localparam int LEAD_BYTES    = 8;
    localparam int BIG_FRAME     = 600;
    localparam int PATTERN_SIZE  = 256;
    localparam rmii_pkg::byte_t PREAMBLE_BYTE = 8'h55;

    // Preamble, SFD and bytes at four dibits each, then the gap
    function automatic int frame_clocks(input int wire_bytes);
        return (LEAD_BYTES + wire_bytes) * 4 + GAP_CLOCKS;
    endfunction

    localparam int TIMEOUT_CYCLES = 2 * (2 * frame_clocks(68) + frame_clocks(24)
        + frame_clocks(3) + 4 * frame_clocks(BIG_FRAME + 4) + 20 * frame_clocks(204)) + 2000;

    logic                  clock;
    logic                  reset;
    rmii_pkg::dibit_t      rmii_receive_data;
    logic                  rmii_receive_data_enable;
    logic                  rmii_receive_data_error;
    logic                  receive_data_enable;
    rmii_pkg::rx_word_t    receive_data;
    logic                  receive_data_valid;
    rmii_pkg::drop_count_t dropped_frames;

    rmii_pkg::byte_t       frame_bytes[$];
    rmii_pkg::rx_word_t    expected_words[$];
    rmii_pkg::rx_word_t    expected_word;
    rmii_pkg::drop_count_t expected_drops;
    bit                    read_pattern [PATTERN_SIZE];
    int                    pattern_index;
    int                    host_mode;
    int                    data_errors;
    int                    drop_errors;
    int                    other_errors;
    int                    cycles;
    integer                seed;
    string                 test_name;

    clock_gen clock_gen0 (
        .clock (clock),
        .reset (reset)
    );

    rmii_receiver dut0 (
        .clock                    (clock),
        .reset                    (reset),
        .rmii_receive_data        (rmii_receive_data),
        .rmii_receive_data_enable (rmii_receive_data_enable),
        .rmii_receive_data_error  (rmii_receive_data_error),
        .receive_data_enable      (receive_data_enable),
        .receive_data             (receive_data),
        .receive_data_valid       (receive_data_valid),
        .dropped_frames           (dropped_frames)
    );

    bind rmii_receiver rmii_receiver_props props0 (
        .clock               (clock),
        .reset               (reset),
        .receive_data        (receive_data),
        .receive_data_valid  (receive_data_valid),
        .receive_data_enable (receive_data_enable),
        .dropped_frames      (dropped_frames),
        .payload_valid       (checker_to_buffer.valid)
    );

    //////////////////////////////////////////////////////////////////////
    // Reference model

    // Bit serial, reflected, result inverted as sent on the wire
    function automatic rmii_pkg::crc_t crc32_of(input rmii_pkg::byte_t bytes[$], input int count);
        rmii_pkg::crc_t crc;
        logic           feedback;
        crc = '1;
        for (int i = 0; i < count; i++) begin
            for (int b = 0; b < `BYTE_WIDTH; b++) begin
                feedback = crc[0] ^ bytes[i][b];
                crc = crc >> 1;
                if (feedback) begin
                    crc = crc ^ `CRC_POLY_REFLECTED;
                end
            end
        end
        return ~crc;
    endfunction

    function automatic bit frame_kept(input rmii_pkg::byte_t bytes[$], input bit rx_error,
                                      input int free_space);
        int             n;
        rmii_pkg::crc_t fcs;
        n = bytes.size();
        if (rx_error || n < `FCS_BYTES + 1 || n - `FCS_BYTES > free_space) begin
            return 1'b0;
        end
        fcs = {bytes[n-1], bytes[n-2], bytes[n-3], bytes[n-4]};
        return fcs == crc32_of(bytes, n - `FCS_BYTES);
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Stimulus helpers

    task automatic make_payload(input int length);
        frame_bytes.delete();
        for (int i = 0; i < length; i++) begin
            frame_bytes.push_back(rmii_pkg::byte_t'($random(seed)));
        end
    endtask

    task automatic append_fcs(input bit corrupt);
        rmii_pkg::crc_t crc;
        crc = crc32_of(frame_bytes, frame_bytes.size());
        for (int k = 0; k < `FCS_BYTES; k++) begin
            frame_bytes.push_back(crc[8*k +: 8]);
        end
        if (corrupt) begin
            frame_bytes[frame_bytes.size() - 1] ^= 8'h10;
        end
    endtask

    task automatic send_frame(input bit error_mid_frame, input int free_space);
        int              n;
        rmii_pkg::byte_t value;
        bit              kept;
        n = frame_bytes.size();
        kept = frame_kept(frame_bytes, error_mid_frame, free_space);
        if (kept) begin
            for (int i = 0; i < n - `FCS_BYTES; i++) begin
                expected_words.push_back({i == n - `FCS_BYTES - 1, frame_bytes[i]});
            end
        end else begin
            expected_drops = expected_drops + 1'b1;
        end
        for (int i = 0; i < LEAD_BYTES + n; i++) begin
            if (i < LEAD_BYTES - 1) begin
                value = PREAMBLE_BYTE;
            end else if (i == LEAD_BYTES - 1) begin
                value = `SFD_BYTE;
            end else begin
                value = frame_bytes[i - LEAD_BYTES];
            end
            for (int d = 0; d < 4; d++) begin
                @(posedge clock);
                rmii_receive_data        <= value[2*d +: 2];
                rmii_receive_data_enable <= 1'b1;
                rmii_receive_data_error  <= error_mid_frame && (i == LEAD_BYTES + n / 2)
                                            && (d == 0);
            end
        end
        @(posedge clock);
        rmii_receive_data        <= '0;
        rmii_receive_data_enable <= 1'b0;
        rmii_receive_data_error  <= 1'b0;
        repeat (GAP_CLOCKS - 1) @(posedge clock);
    endtask

    task automatic finish_test();
        while (expected_words.size() != 0) @(posedge clock);
        assert (dropped_frames == expected_drops) else begin
            drop_errors++;
            $display("[ERROR] %s: expected %0d, actual %0d", test_name, expected_drops,
                     dropped_frames);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Tests

    initial begin
        int sent;
        seed                     = 32'ha26e_67e9;
        rmii_receive_data        = '0;
        rmii_receive_data_enable = 1'b0;
        rmii_receive_data_error  = 1'b0;
        receive_data_enable      = 1'b0;
        host_mode                = 1;
        expected_drops           = '0;
        data_errors              = 0;
        drop_errors              = 0;
        other_errors             = 0;
        wait (reset == 1'b0);
        @(posedge clock);

        test_name = "good_frame_64";
        make_payload(64);
        append_fcs(1'b0);
        send_frame(1'b0, `RX_BUFFER_DEPTH);
        finish_test();

        test_name = "bad_fcs";
        make_payload(64);
        append_fcs(1'b1);
        send_frame(1'b0, `RX_BUFFER_DEPTH);
        finish_test();

        test_name = "rx_error_and_short";
        make_payload(20);
        append_fcs(1'b0);
        send_frame(1'b1, `RX_BUFFER_DEPTH);
        make_payload(3);
        send_frame(1'b0, `RX_BUFFER_DEPTH);
        finish_test();

        // Host idle until every big frame is in
        test_name = "overflow";
        host_mode <= 0;
        sent = 0;
        while (sent <= `RX_BUFFER_DEPTH) begin
            make_payload(BIG_FRAME);
            append_fcs(1'b0);
            send_frame(1'b0, `RX_BUFFER_DEPTH - sent);
            sent += BIG_FRAME;
        end
        host_mode <= 1;
        finish_test();

        test_name = "random_frames";
        for (int i = 0; i < PATTERN_SIZE; i++) begin
            read_pattern[i] = ($random(seed) & 3) != 0;
        end
        host_mode <= 2;
        for (int f = 0; f < 20; f++) begin
            make_payload(5 + (($random(seed) & 32'h7fff_ffff) % 196));
            append_fcs(($random(seed) & 7) == 0);
            send_frame(1'b0, `RX_BUFFER_DEPTH);
        end
        finish_test();

        other_errors += dut0.props0.assertion_failures;
        $display("Errors: data %0d, drop count %0d, other %0d", data_errors, drop_errors,
                 other_errors);
        if (data_errors + drop_errors + other_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // Host side and comparing process

    always @(posedge clock) begin
        case (host_mode)
            0: receive_data_enable <= 1'b0;
            1: receive_data_enable <= 1'b1;
            default: begin
                receive_data_enable <= read_pattern[pattern_index % PATTERN_SIZE];
                pattern_index       <= pattern_index + 1;
            end
        endcase
    end

    initial pattern_index = 0;

    // Words popped at the next rising edge are checked here
    always @(negedge clock) begin
        if (!reset && receive_data_valid && receive_data_enable) begin
            assert (expected_words.size() != 0) else begin
                other_errors++;
                $display("[ERROR] %s: host got byte %h although no byte was expected",
                         test_name, receive_data);
            end
            if (expected_words.size() != 0) begin
                expected_word = expected_words.pop_front();
                assert (receive_data === expected_word) else begin
                    data_errors++;
                    $display("[ERROR] %s: expected %h, actual %h", test_name, expected_word,
                             receive_data);
                end
            end
        end
    end

    initial cycles = 0;

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout in %s after %0d cycles, bytes still missing at the host",
                     test_name, cycles);
            $display("Simulation failed");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* compile.f */
+incdir+verilog
verilog/rmii_pkg.sv
verilog/byte_stream_if.sv
verilog/rmii_byte_packager.sv
verilog/frame_checker.sv
verilog/receive_buffer.sv
verilog/rmii_receiver.sv
test/clock_gen.sv
test/rmii_receiver_props.sv
test/rmii_receiver_tb.sv

/* Makefile */
VERILATOR       = verilator
VERILATOR_FLAGS = --binary --timing --assert -Wno-fatal -j 0
TOP_MODULE      = rmii_receiver_tb
FILE_LIST       = compile.f
BUILD_DIR       = obj_dir
LOG_FILE        = simulation.log
PASS_MESSAGE    = Simulation completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP_MODULE) \
		-f $(FILE_LIST) -Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP_MODULE) 2>&1 | tee $(LOG_FILE)
	@if grep -q "$(PASS_MESSAGE)" $(LOG_FILE); then \
		echo "Run passed, see $(LOG_FILE)"; \
	else \
		echo "Pass line not found in $(LOG_FILE)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG_FILE)
